//--- Makefile
# Verilator build and run of the chess evaluator testbench.

VERILATOR ?= verilator
TOP       ?= eval_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- attack/attack_gen.sv
`timescale 1ns/10ps
`include "vchess_consts.svh"

module attack_gen
  (
   input logic   clk,
   input logic   reset,
   attack_if.gen atk
   );
   import vchess_pkg::*;

   // Orthogonal directions first, diagonals after.
   localparam int DIR_N  = 0;
   localparam int DIR_S  = 1;
   localparam int DIR_E  = 2;
   localparam int DIR_W  = 3;
   localparam int DIR_NE = 4;
   localparam int DIR_NW = 5;
   localparam int DIR_SE = 6;
   localparam int DIR_SW = 7;

   attack_state_t state;
   logic [2:0]    step;
   logic [63:0]   white_map;
   logic [63:0]   black_map;
   logic [63:0]   empty_map;
   logic [63:0]   white_front [8];
   logic [63:0]   black_front [8];
   logic [63:0]   white_hits;
   logic [63:0]   black_hits;
   logic [63:0]   w_pawn;
   logic [63:0]   w_knight;
   logic [63:0]   w_king;
   logic [63:0]   w_orth;
   logic [63:0]   w_diag;
   logic [63:0]   b_pawn;
   logic [63:0]   b_knight;
   logic [63:0]   b_king;
   logic [63:0]   b_orth;
   logic [63:0]   b_diag;
   logic [63:0]   occupied;

   // One step in a direction, dropping squares that would wrap a file edge.
   function automatic logic [63:0] shift_dir(input logic [63:0] m, input int dir);
      logic [63:0] r;
      case (dir)
         DIR_N:   r = m << 8;
         DIR_S:   r = m >> 8;
         DIR_E:   r = (m & ~`FILE_H_MASK) << 1;
         DIR_W:   r = (m & ~`FILE_A_MASK) >> 1;
         DIR_NE:  r = (m & ~`FILE_H_MASK) << 9;
         DIR_NW:  r = (m & ~`FILE_A_MASK) << 7;
         DIR_SE:  r = (m & ~`FILE_H_MASK) >> 7;
         DIR_SW:  r = (m & ~`FILE_A_MASK) >> 9;
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic logic [63:0] knight_targets(input logic [63:0] m);
      return shift_dir(shift_dir(m, DIR_N), DIR_NE) | shift_dir(shift_dir(m, DIR_N), DIR_NW) |
             shift_dir(shift_dir(m, DIR_S), DIR_SE) | shift_dir(shift_dir(m, DIR_S), DIR_SW) |
             shift_dir(shift_dir(m, DIR_E), DIR_NE) | shift_dir(shift_dir(m, DIR_E), DIR_SE) |
             shift_dir(shift_dir(m, DIR_W), DIR_NW) | shift_dir(shift_dir(m, DIR_W), DIR_SW);
   endfunction

   function automatic logic [63:0] king_targets(input logic [63:0] m);
      logic [63:0] r;
      r = '0;
      for (int d = 0; d < 8; d++)
         r = r | shift_dir(m, d);
      return r;
   endfunction

   // Counts above the port width saturate.
   function automatic logic [`POP_WIDTH-1:0] pop_sat(input logic [63:0] m);
      logic [`POP_WIDTH:0] n;
      n = '0;
      for (int i = 0; i < 64; i++)
         n = n + (`POP_WIDTH+1)'(m[i]);
      return n[`POP_WIDTH] ? '1 : n[`POP_WIDTH-1:0];
   endfunction

   always_comb
   begin
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         w_pawn[sq]   = (atk.board[sq] == WHITE_PAWN);
         w_knight[sq] = (atk.board[sq] == WHITE_KNIGHT);
         w_king[sq]   = (atk.board[sq] == WHITE_KING);
         w_orth[sq]   = (atk.board[sq] == WHITE_ROOK) || (atk.board[sq] == WHITE_QUEEN);
         w_diag[sq]   = (atk.board[sq] == WHITE_BISHOP) || (atk.board[sq] == WHITE_QUEEN);
         b_pawn[sq]   = (atk.board[sq] == BLACK_PAWN);
         b_knight[sq] = (atk.board[sq] == BLACK_KNIGHT);
         b_king[sq]   = (atk.board[sq] == BLACK_KING);
         b_orth[sq]   = (atk.board[sq] == BLACK_ROOK) || (atk.board[sq] == BLACK_QUEEN);
         b_diag[sq]   = (atk.board[sq] == BLACK_BISHOP) || (atk.board[sq] == BLACK_QUEEN);
         occupied[sq] = (atk.board[sq] != EMPTY);
      end
   end

   // Squares reached by every frontier on this step.
   always_comb
   begin
      white_hits = '0;
      black_hits = '0;
      for (int d = 0; d < 8; d++)
      begin
         white_hits = white_hits | shift_dir(white_front[d], d);
         black_hits = black_hits | shift_dir(black_front[d], d);
      end
   end

   // ------------------------------------------------------------
   // Control
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state                 <= ATK_IDLE;
         step                  <= '0;
         atk.is_attacking_done <= 1'b0;
      end
      else
      begin
         atk.is_attacking_done <= 1'b0;
         case (state)
            ATK_IDLE:
            begin
               step <= '0;
               if (atk.board_valid)
                  state <= ATK_RAY;
            end
            ATK_RAY:
            begin
               step <= step + 3'd1;
               if (step == 3'(`RAY_STEPS - 1))
                  state <= ATK_COUNT;
            end
            ATK_COUNT:
               state <= ATK_DONE;
            ATK_DONE:
            begin
               atk.is_attacking_done <= 1'b1;
               state                 <= ATK_IDLE;
            end
         endcase
      end
   end

   // ------------------------------------------------------------
   // Attack maps and ray frontiers
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (state == ATK_IDLE && atk.board_valid)
      begin
         white_map <= shift_dir(w_pawn, DIR_NE) | shift_dir(w_pawn, DIR_NW) |
                      knight_targets(w_knight) | king_targets(w_king);
         black_map <= shift_dir(b_pawn, DIR_SE) | shift_dir(b_pawn, DIR_SW) |
                      knight_targets(b_knight) | king_targets(b_king);
         empty_map <= ~occupied;
         for (int d = 0; d < 8; d++)
         begin
            white_front[d] <= (d < 4) ? w_orth : w_diag;
            black_front[d] <= (d < 4) ? b_orth : b_diag;
         end
      end
      else if (state == ATK_RAY)
      begin
         white_map <= white_map | white_hits;
         black_map <= black_map | black_hits;
         for (int d = 0; d < 8; d++)
         begin
            white_front[d] <= shift_dir(white_front[d], d) & empty_map; // Stop on blockers.
            black_front[d] <= shift_dir(black_front[d], d) & empty_map;
         end
      end
      else if (state == ATK_COUNT)
      begin
         atk.white_pop <= pop_sat(white_map);
         atk.black_pop <= pop_sat(black_map);
      end
   end

endmodule

//--- common/attack_if.sv
`timescale 1ns/10ps
`include "vchess_consts.svh"

interface attack_if;
   import vchess_pkg::*;

   board_t                board;
   logic                  board_valid;
   logic [`POP_WIDTH-1:0] white_pop;
   logic [`POP_WIDTH-1:0] black_pop;
   logic                  is_attacking_done; // One pulse per board_valid.

   modport gen
     (
      input  board,
      input  board_valid,
      output white_pop,
      output black_pop,
      output is_attacking_done
      );

   modport eval
     (
      output board,
      output board_valid,
      input  white_pop,
      input  black_pop,
      input  is_attacking_done
      );

endinterface

//--- common/vchess_consts.svh
`ifndef VCHESS_CONSTS_SVH
`define VCHESS_CONSTS_SVH

// ------------------------------------------------------------
// Board geometry
// ------------------------------------------------------------
`define PIECE_WIDTH     4
`define BOARD_SQUARES   64
`define BOARD_SIDE      8
`define BOARD_WIDTH     256
`define FILE_A_MASK     64'h0101_0101_0101_0101
`define FILE_H_MASK     64'h8080_8080_8080_8080
`define CENTRE_LO       2
`define CENTRE_HI       5
`define RAY_STEPS       7 // Longest slide on an 8x8 board.

// ------------------------------------------------------------
// Scoring
// ------------------------------------------------------------
`define EVAL_WIDTH      16
`define POP_WIDTH       6
`define VALUE_PAWN      100
`define VALUE_KNIGHT    300
`define VALUE_BISHOP    310
`define VALUE_ROOK      500
`define VALUE_QUEEN     900
`define VALUE_KING      0
`define PAWN_ADVANCE    5  // Per rank advanced.
`define CENTRE_BONUS    10
`define POP_WEIGHT      10 // Per attacked square.
`define EVAL_CREDITS    1

`endif

//--- common/vchess_pkg.sv
`include "vchess_consts.svh"

package vchess_pkg;

   // Bit 3 of a square code marks a black piece.
   typedef enum logic [`PIECE_WIDTH-1:0] {
      EMPTY        = 4'd0,
      WHITE_PAWN   = 4'd1,
      WHITE_KNIGHT = 4'd2,
      WHITE_BISHOP = 4'd3,
      WHITE_ROOK   = 4'd4,
      WHITE_QUEEN  = 4'd5,
      WHITE_KING   = 4'd6,
      BLACK_PAWN   = 4'd9,
      BLACK_KNIGHT = 4'd10,
      BLACK_BISHOP = 4'd11,
      BLACK_ROOK   = 4'd12,
      BLACK_QUEEN  = 4'd13,
      BLACK_KING   = 4'd14
   } piece_t;

   // Square 0 is a1, index is rank * 8 + file.
   typedef piece_t [`BOARD_SQUARES-1:0] board_t;

   typedef enum logic [2:0] {
      EVAL_IDLE,
      EVAL_WAIT_ATTACK,
      EVAL_T1,
      EVAL_T2,
      EVAL_T3,
      EVAL_T4,
      EVAL_T5
   } eval_state_t;

   typedef enum logic [1:0] {
      ATK_IDLE,
      ATK_RAY,
      ATK_COUNT,
      ATK_DONE
   } attack_state_t;

endpackage

//--- dv/eval_checker.sv
`timescale 1ns/10ps
`include "vchess_consts.svh"

module eval_checker
  (
   input logic                          clk,
   input logic                          reset,
   input logic                          board_valid,
   input logic                          clear_eval,
   input logic signed [`EVAL_WIDTH-1:0] eval,
   input logic                          eval_valid,
   input logic                          insufficient_material,
   input logic                          credit
   );

   int credits;      // Credits the host holds, as seen from the evaluator.
   int failures = 0; // Failed assertions, read by the testbench at the end.

   always_ff @(posedge clk)
   begin
      if (reset)
         credits <= `EVAL_CREDITS;
      else
         credits <= credits - int'(board_valid) + int'(credit);
   end

   // ------------------------------------------------------------
   // Handshake
   // ------------------------------------------------------------
   // A returned credit may be spent in the cycle of its pulse.
   board_needs_credit: assert property (@(posedge clk) disable iff (reset)
      board_valid |-> credits + int'(credit) > 0)
      else
      begin
         $error("board_valid sent while the host holds no credit");
         failures++;
      end

   result_held: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid && $stable(eval) &&
                                    $stable(insufficient_material))
      else
      begin
         $error("Result changed or eval_valid dropped before clear_eval");
         failures++;
      end

   credit_after_clear: assert property (@(posedge clk) disable iff (reset)
      clear_eval && eval_valid |=> credit && !eval_valid)
      else
      begin
         $error("No credit pulse one cycle after clear_eval");
         failures++;
      end

   // ------------------------------------------------------------
   // Reset
   // ------------------------------------------------------------
   quiet_after_reset: assert property (@(posedge clk)
      reset |=> !eval_valid && !credit)
      else
      begin
         $error("eval_valid or credit high right after reset");
         failures++;
      end

endmodule

//--- dv/eval_tb.sv
`timescale 1ns/10ps
`include "vchess_consts.svh"

module eval_tb;
   import vchess_pkg::*;

   localparam int RESET_CYCLES    = 16;
   localparam int CYCLES_PER_TEST = 40;

   logic                          clk;
   logic                          reset;
   board_t                        board_in;
   logic                          board_valid;
   logic                          white_to_move;
   logic                          use_random_bit;
   logic                          random_bit;
   logic                          clear_eval;
   logic signed [`EVAL_WIDTH-1:0] eval;
   logic                          eval_valid;
   logic                          insufficient_material;
   logic                          credit;

   logic [`BOARD_WIDTH-1:0] trace_board [$];
   logic [2:0]              trace_ctrl [$]; // White to move, use random, random bit.
   logic [`EVAL_WIDTH-1:0]  trace_eval [$];
   logic                    trace_insufficient [$];

   int   credits;
   int   error_count;
   int   test_count;
   int   cycle_count;
   int   cycle_limit;
   int   seed;
   logic trace_loaded;

   eval_top dut
     (
      .clk                   (clk),
      .reset                 (reset),
      .board_in              (board_in),
      .board_valid           (board_valid),
      .white_to_move         (white_to_move),
      .use_random_bit        (use_random_bit),
      .random_bit            (random_bit),
      .clear_eval            (clear_eval),
      .eval                  (eval),
      .eval_valid            (eval_valid),
      .insufficient_material (insufficient_material),
      .credit                (credit)
      );

   bind evaluate eval_checker u_checker
     (
      .clk                   (clk),
      .reset                 (reset),
      .board_valid           (board_valid),
      .clear_eval            (clear_eval),
      .eval                  (eval),
      .eval_valid            (eval_valid),
      .insufficient_material (insufficient_material),
      .credit                (credit)
      );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic compare_value(input string name, input logic [`EVAL_WIDTH-1:0] actual,
                                input logic [`EVAL_WIDTH-1:0] expected);
      if (actual !== expected)
      begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
         error_count++;
      end
   endtask

   // ------------------------------------------------------------
   // Trace loading
   // ------------------------------------------------------------
   task automatic load_trace(output logic ok);
      int                     fd;
      int                     fields;
      string                  line;
      logic [31:0]            rank [8];
      logic                   wtm;
      logic                   use_rnd;
      logic                   rnd;
      logic [`EVAL_WIDTH-1:0] expected_eval;
      logic                   expected_insufficient;
      ok = 1'b0;
      fd = $fopen("dv/eval_trace.txt", "r");
      if (fd != 0)
      begin
         ok = 1'b1;
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                rank[7], rank[6], rank[5], rank[4], rank[3], rank[2],
                                rank[1], rank[0], wtm, use_rnd, rnd, expected_eval,
                                expected_insufficient);
               if (fields == 13)
               begin
                  trace_board.push_back({rank[7], rank[6], rank[5], rank[4],
                                         rank[3], rank[2], rank[1], rank[0]});
                  trace_ctrl.push_back({wtm, use_rnd, rnd});
                  trace_eval.push_back(expected_eval);
                  trace_insufficient.push_back(expected_insufficient);
               end
               else
                  ok = 1'b0;
            end
         end
         $fclose(fd);
      end
      if (trace_board.size() == 0)
         ok = 1'b0;
   endtask

   task automatic run_test(input int idx);
      int errors_before;
      int hold;
      errors_before = error_count;
      while (credits == 0)
         @(negedge clk);
      board_in = board_t'(trace_board[idx]);
      {white_to_move, use_random_bit, random_bit} = trace_ctrl[idx];
      board_valid = 1'b1;
      credits--;
      @(negedge clk);
      board_valid = 1'b0;
      while (!eval_valid)
         @(negedge clk);
      compare_value("eval", eval, trace_eval[idx]);
      compare_value("insufficient_material", `EVAL_WIDTH'(insufficient_material),
                    `EVAL_WIDTH'(trace_insufficient[idx]));
      hold = $unsigned($random(seed)) % 6; // Host back-pressure.
      repeat (hold)
      begin
         @(negedge clk);
         compare_value("eval", eval, trace_eval[idx]);
         compare_value("insufficient_material", `EVAL_WIDTH'(insufficient_material),
                       `EVAL_WIDTH'(trace_insufficient[idx]));
         compare_value("eval_valid", `EVAL_WIDTH'(eval_valid), `EVAL_WIDTH'(1));
      end
      clear_eval = 1'b1;
      @(negedge clk);
      clear_eval = 1'b0;
      compare_value("credit", `EVAL_WIDTH'(credit), `EVAL_WIDTH'(1));
      compare_value("eval_valid", `EVAL_WIDTH'(eval_valid), `EVAL_WIDTH'(0));
      if (credit)
         credits++;
      test_count++;
      $display("Test %0d: %s (hold %0d)", idx, (error_count == errors_before) ? "ok" : "mismatch",
               hold);
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial
   begin
      reset          = 1'b1;
      board_in       = board_t'(`BOARD_WIDTH'(0));
      board_valid    = 1'b0;
      white_to_move  = 1'b0;
      use_random_bit = 1'b0;
      random_bit     = 1'b0;
      clear_eval     = 1'b0;
      credits        = `EVAL_CREDITS;
      error_count    = 0;
      test_count     = 0;
      seed           = 80545;
      load_trace(trace_loaded);
      if (!trace_loaded)
      begin
         $display("Trace file dv/eval_trace.txt is missing or has a bad line");
         error_count++;
      end
      else
      begin
         cycle_limit = trace_board.size() * CYCLES_PER_TEST + RESET_CYCLES;
         repeat (RESET_CYCLES) @(negedge clk);
         reset = 1'b0;
         for (int i = 0; i < trace_board.size(); i++)
            run_test(i);
      end
      error_count += dut.u_evaluate.u_checker.failures;
      $display("%0d tests run, %0d errors", test_count, error_count);
      if (error_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   initial
   begin
      cycle_count = 0;
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run stopped after %0d cycles with tests unfinished", cycle_count);
      $display("Done: errors found");
      $finish;
   end

endmodule

//--- dv/eval_trace.txt
# Ranks 8 down to 1, each 8 hex piece codes from file h to file a, then
# white_to_move use_random_bit random_bit expected_eval(hex) expected_insufficient
# K vs K and K+B vs K, drawn on material whatever the random bit.
E0000000 00000000 00000000 00000000 00000000 00000000 00000000 00000006 1 1 1 0000 1
E0000000 00000000 00000000 00000000 00003000 00000000 00000000 00000006 0 1 1 0000 1
# K+P vs K is not a draw.
E0000000 00000000 00000000 00000000 00010000 00000000 00000000 00000006 1 0 1 0082 0
# White rook, then the same board with the random bit.
E0000000 00000000 00000000 00000000 00000000 00000000 00000000 40000006 0 0 0 0276 0
E0000000 00000000 00000000 00000000 00000000 00000000 00000000 40000006 1 1 1 0277 0
E0000000 00000000 00000000 00000000 00000000 00000000 00000000 40000006 0 1 1 0275 0
E0000000 00000000 00000000 00000000 00000000 00000000 00000000 40000006 1 1 0 0276 0
# Black queen and advanced pawn.
E000000D 00000000 00000000 00000000 00000000 00000900 00000000 00000006 1 0 1 FB28 0
# Sliding rays stopped by blockers.
E0000000 0000A000 00000000 00000000 0C005000 00000000 00000000 00000006 1 0 0 00BE 0
000E0000 00000000 00000000 00000090 00000300 00000000 00000000 00060000 0 1 1 010D 0
# Two knights are enough material.
E0000000 00000000 00000000 00000000 00000000 00000000 00000000 02000026 1 0 0 0294 0

//--- evaluate/evaluate.sv
`timescale 1ns/10ps
`include "vchess_consts.svh"

module evaluate
  (
   input  logic                          clk,
   input  logic                          reset,
   input  vchess_pkg::board_t            board_in,
   input  logic                          board_valid,
   input  logic                          white_to_move,
   input  logic                          use_random_bit,
   input  logic                          random_bit,
   input  logic                          clear_eval,
   attack_if.eval                        atk,
   output logic signed [`EVAL_WIDTH-1:0] eval,
   output logic                          eval_valid,
   output logic                          insufficient_material,
   output logic                          credit
   );
   import vchess_pkg::*;

   eval_state_t                  state;
   board_t                       board;
   logic                         white_to_move_l;
   logic                         use_random_l;
   logic                         random_l;
   logic signed [`EVAL_WIDTH-1:0] score_t1 [`BOARD_SQUARES];
   logic signed [`EVAL_WIDTH-1:0] sum_a_t2 [16];
   logic signed [`EVAL_WIDTH-1:0] sum_b_t3 [4];
   logic signed [`EVAL_WIDTH-1:0] eval_t4;
   logic [6:0]                   w_minor;
   logic [6:0]                   w_major;
   logic [6:0]                   b_minor;
   logic [6:0]                   b_major;
   logic [6:0]                   w_minor_t1;
   logic [6:0]                   w_major_t1;
   logic [6:0]                   b_minor_t1;
   logic [6:0]                   b_major_t1;
   logic                         insufficient_t2;
   logic                         insufficient_t3;
   logic signed [`POP_WIDTH:0]   pop_diff_t1;
   logic signed [1:0]            random_t1;
   logic signed [`EVAL_WIDTH-1:0] pop_score_t2;
   logic signed [`EVAL_WIDTH-1:0] mob_t3;

   // Piece value plus piece-square bonus, negated for black.
   function automatic logic signed [`EVAL_WIDTH-1:0] square_score(input piece_t p,
                                                                  input int sq);
      int   rank;
      int   file;
      int   value;
      logic centre;
      rank   = sq / `BOARD_SIDE;
      file   = sq % `BOARD_SIDE;
      centre = (rank >= `CENTRE_LO) && (rank <= `CENTRE_HI) &&
               (file >= `CENTRE_LO) && (file <= `CENTRE_HI);
      case (p)
         WHITE_PAWN:   value = `VALUE_PAWN + `PAWN_ADVANCE * (rank - 1);
         WHITE_KNIGHT: value = `VALUE_KNIGHT + (centre ? `CENTRE_BONUS : 0);
         WHITE_BISHOP: value = `VALUE_BISHOP + (centre ? `CENTRE_BONUS : 0);
         WHITE_ROOK:   value = `VALUE_ROOK;
         WHITE_QUEEN:  value = `VALUE_QUEEN;
         WHITE_KING:   value = `VALUE_KING;
         BLACK_PAWN:   value = -(`VALUE_PAWN + `PAWN_ADVANCE * (6 - rank));
         BLACK_KNIGHT: value = -(`VALUE_KNIGHT + (centre ? `CENTRE_BONUS : 0));
         BLACK_BISHOP: value = -(`VALUE_BISHOP + (centre ? `CENTRE_BONUS : 0));
         BLACK_ROOK:   value = -`VALUE_ROOK;
         BLACK_QUEEN:  value = -`VALUE_QUEEN;
         BLACK_KING:   value = -`VALUE_KING;
         default:      value = 0;
      endcase
      return value[`EVAL_WIDTH-1:0];
   endfunction

   // The generator sees the board on the same edge that latches it here.
   assign atk.board       = board_in;
   assign atk.board_valid = board_valid && (state == EVAL_IDLE);

   assign eval                  = eval_t4;
   assign insufficient_material = insufficient_t3;

   always_ff @(posedge clk)
   begin
      if (state == EVAL_IDLE && board_valid)
      begin
         board           <= board_in;
         white_to_move_l <= white_to_move;
         use_random_l    <= use_random_bit;
         random_l        <= random_bit;
      end
   end

   // Pawns, rooks and queens count as major here.
   always_comb
   begin
      w_minor = '0;
      w_major = '0;
      b_minor = '0;
      b_major = '0;
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         case (board[sq])
            WHITE_KNIGHT, WHITE_BISHOP:          w_minor = w_minor + 7'd1;
            WHITE_PAWN, WHITE_ROOK, WHITE_QUEEN: w_major = w_major + 7'd1;
            BLACK_KNIGHT, BLACK_BISHOP:          b_minor = b_minor + 7'd1;
            BLACK_PAWN, BLACK_ROOK, BLACK_QUEEN: b_major = b_major + 7'd1;
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Score pipeline
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
         score_t1[sq] <= square_score(board[sq], sq);
      for (int i = 0; i < 16; i++)
         sum_a_t2[i] <= score_t1[4*i] + score_t1[4*i+1] + score_t1[4*i+2] + score_t1[4*i+3];
      for (int j = 0; j < 4; j++)
         sum_b_t3[j] <= sum_a_t2[4*j] + sum_a_t2[4*j+1] + sum_a_t2[4*j+2] + sum_a_t2[4*j+3];

      w_minor_t1      <= w_minor;
      w_major_t1      <= w_major;
      b_minor_t1      <= b_minor;
      b_major_t1      <= b_major;
      insufficient_t2 <= (w_major_t1 == 7'd0) && (b_major_t1 == 7'd0) &&
                         (w_minor_t1 <= 7'd1) && (b_minor_t1 <= 7'd1);
      insufficient_t3 <= insufficient_t2;

      pop_diff_t1  <= $signed({1'b0, atk.white_pop}) - $signed({1'b0, atk.black_pop});
      pop_score_t2 <= `EVAL_WIDTH'(`POP_WEIGHT * pop_diff_t1);
      if (use_random_l && random_l)
         random_t1 <= white_to_move_l ? 2'sd1 : -2'sd1;
      else
         random_t1 <= 2'sd0;
      mob_t3 <= pop_score_t2 + random_t1;

      if (insufficient_t3)
         eval_t4 <= '0; // Drawn on material.
      else
         eval_t4 <= mob_t3 + sum_b_t3[0] + sum_b_t3[1] + sum_b_t3[2] + sum_b_t3[3];
   end

   // ------------------------------------------------------------
   // Sequencing and credit return
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= EVAL_IDLE;
         eval_valid <= 1'b0;
         credit     <= 1'b0;
      end
      else
      begin
         credit <= 1'b0;
         case (state)
            EVAL_IDLE:
            begin
               if (board_valid)
                  state <= EVAL_WAIT_ATTACK;
            end
            EVAL_WAIT_ATTACK:
            begin
               if (atk.is_attacking_done)
                  state <= EVAL_T1;
            end
            EVAL_T1: state <= EVAL_T2;
            EVAL_T2: state <= EVAL_T3;
            EVAL_T3: state <= EVAL_T4;
            EVAL_T4: state <= EVAL_T5;
            EVAL_T5:
            begin
               eval_valid <= 1'b1; // Held until the host clears it.
               if (clear_eval && eval_valid)
               begin
                  eval_valid <= 1'b0;
                  credit     <= 1'b1;
                  state      <= EVAL_IDLE;
               end
            end
            default: state <= EVAL_IDLE;
         endcase
      end
   end

endmodule

//--- flist.f
+incdir+common
dv/eval_checker.sv
common/vchess_pkg.sv
common/attack_if.sv
attack/attack_gen.sv
evaluate/evaluate.sv
rtl/eval_top.sv
dv/eval_tb.sv

//--- rtl/eval_top.sv
`timescale 1ns/10ps
`include "vchess_consts.svh"

module eval_top
  (
   input  logic                          clk,
   input  logic                          reset,
   input  vchess_pkg::board_t            board_in,
   input  logic                          board_valid,
   input  logic                          white_to_move,
   input  logic                          use_random_bit,
   input  logic                          random_bit,
   input  logic                          clear_eval,
   output logic signed [`EVAL_WIDTH-1:0] eval,
   output logic                          eval_valid,
   output logic                          insufficient_material,
   output logic                          credit
   );

   // Board and mobility counts between the two blocks.
   attack_if atk ();

   attack_gen u_attack_gen
     (
      .clk   (clk),
      .reset (reset),
      .atk   (atk.gen)
      );

   evaluate u_evaluate
     (
      .clk                   (clk),
      .reset                 (reset),
      .board_in              (board_in),
      .board_valid           (board_valid),
      .white_to_move         (white_to_move),
      .use_random_bit        (use_random_bit),
      .random_bit            (random_bit),
      .clear_eval            (clear_eval),
      .atk                   (atk.eval),
      .eval                  (eval),
      .eval_valid            (eval_valid),
      .insufficient_material (insufficient_material),
      .credit                (credit)
      );

endmodule
